// ==== build.f ====
+incdir+rtl
rtl/i2c_pkg.sv
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_seq.sv
rtl/eeprom_ctrl_top.sv
sim/eeprom_model.sv
sim/tb_eeprom.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_eeprom
FILELIST  = build.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/eeprom_input.txt ====
// op addr data expect, all hex, one operation per line
// op 1 write, 2 read (expect = byte read), 3 write to refusing device, 4 write + ignored strobe
2 005 00 5f  // untouched, block 0
2 705 00 bf  // same low byte, block 7
1 005 a7 00
2 005 00 a7
2 705 00 bf
2 3c2 00 f8
3 123 44 00
2 123 00 59  // refused write left it alone
4 200 11 ee
2 200 00 11
1 010 01 00
1 111 02 00
1 222 03 00
1 333 04 00
1 7ff 05 00
2 7ff 00 05
2 333 00 04
2 222 00 03
2 111 00 02
2 010 00 01

// ==== sim/tb_eeprom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module tb_eeprom
    import i2c_pkg::*;
    import eeprom_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int MAX_OPS      = 32;
    localparam int QUIET_CYCLES = 64;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        wr;
    logic        rd;
    ee_addr_t    addr;
    i2c_byte_t   wr_data;
    i2c_byte_t   rd_data;
    logic        busy;
    logic        ack;
    logic        nack_err;
    logic        scl;
    logic        dut_pull;
    logic        model_pull;
    logic        refuse;
    logic        sda_bus;
    logic [15:0] stim [0:4*MAX_OPS-1]; // op, addr, data, expected per operation
    i2c_byte_t   shadow [0:2047];
    int          num_ops;
    int          cycles = 0;
    int          cycle_limit = 0;

    assign sda_bus = !(dut_pull || model_pull); // pull-up

    eeprom_ctrl_top u_eeprom_ctrl_top (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .busy         (busy),
        .ack          (ack),
        .nack_err     (nack_err),
        .scl          (scl),
        .sda_pull_low (dut_pull),
        .sda_in       (sda_bus)
    );

    eeprom_model u_eeprom_model (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl          (scl),
        .sda          (sda_bus),
        .refuse       (refuse),
        .sda_pull_low (model_pull)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("controller stopped answering, no ack after %0d cycles", cycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // power-up content of the device
    function automatic i2c_byte_t fill_byte(input ee_addr_t a);
        return a[7:0] ^ 8'h5A ^ {a[10:8], 5'b00000};
    endfunction

    task automatic start_transfer(input logic is_read, input ee_addr_t a, input i2c_byte_t d);
        @(negedge CLK);
        wr      = !is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        while (!ack) begin
            @(negedge CLK);
        end
    endtask

    task automatic do_write(input ee_addr_t a, input i2c_byte_t d, input logic refused);
        refuse = refused;
        start_transfer(1'b0, a, d);
        wait_ack();
        compare($sformatf("nack_err after write to %h", a), 8'(nack_err), 8'(refused));
        refuse = 1'b0;
        if (!refused) begin
            shadow[a] = d;
        end
    endtask

    task automatic do_read(input ee_addr_t a, input i2c_byte_t exp);
        start_transfer(1'b1, a, 8'h00);
        wait_ack();
        compare($sformatf("nack_err after read of %h", a), 8'(nack_err), 8'd0);
        compare($sformatf("rd_data of %h vs file", a), rd_data, exp);
        compare($sformatf("rd_data of %h vs memory copy", a), rd_data, shadow[a]);
    endtask

    task automatic write_with_ignored_strobe(input ee_addr_t a, input i2c_byte_t d,
                                             input i2c_byte_t ignored);
        start_transfer(1'b0, a, d);
        repeat (4) @(negedge CLK);
        compare("busy during write", 8'(busy), 8'd1);
        wr      = 1'b1; // dropped by the controller
        rd      = 1'b1;
        wr_data = ignored;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        wait_ack();
        compare("nack_err after write", 8'(nack_err), 8'd0);
        shadow[a] = d;
        repeat (QUIET_CYCLES) begin
            @(negedge CLK);
            compare("ack with no request", 8'(ack), 8'd0);
            compare("busy with no request", 8'(busy), 8'd0);
        end
    endtask

    initial begin
        int        op;
        ee_addr_t  a;
        i2c_byte_t d;
        i2c_byte_t exp;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        refuse  = 1'b0;
        for (int i = 0; i < 4 * MAX_OPS; i++) begin
            stim[i] = '0;
        end
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = fill_byte(11'(i));
        end
        $readmemh("sim/eeprom_input.txt", stim);
        num_ops = 0;
        while (num_ops < MAX_OPS && stim[4 * num_ops] != 16'd0) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            $display("no operations found in sim/eeprom_input.txt");
            $display("TESTS FAILED");
            $fatal(1, "empty stimulus");
        end
        cycle_limit = RESET_CYCLES + num_ops * 40 * 4 * `SCL_QUARTER;

        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        compare("busy after reset", 8'(busy), 8'd0);
        compare("ack after reset", 8'(ack), 8'd0);
        compare("nack_err after reset", 8'(nack_err), 8'd0);
        compare("scl after reset", 8'(scl), 8'd1);
        compare("sda_pull_low after reset", 8'(dut_pull), 8'd0);

        for (int n = 0; n < num_ops; n++) begin
            op  = int'(stim[4 * n][3:0]);
            a   = stim[4 * n + 1][10:0];
            d   = stim[4 * n + 2][7:0];
            exp = stim[4 * n + 3][7:0];
            case (op)
                1:       do_write(a, d, 1'b0);
                2:       do_read(a, exp);
                3:       do_write(a, d, 1'b1);
                4:       write_with_ignored_strobe(a, d, exp);
                default: begin
                    $display("unknown operation %0d in the stimulus file", op);
                    $display("TESTS FAILED");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_model (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  scl,
    input  wire  sda,
    input  wire  refuse,        // NACK the control byte
    output logic sda_pull_low
);

    logic [7:0] mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic [3:0] cnt;       // 8 after the data bits, 9 after the ack bit
    logic [7:0] sh;
    logic [1:0] byte_idx;  // 0 control, 1 word address, 2 data
    logic [2:0] blk;
    logic [7:0] lo;
    logic       listen;
    logic       talk;
    logic       addr_ok;

    assign addr_ok = (sh[7:4] == `DEV_TYPE) && !refuse;

    initial begin
        logic [10:0] a;
        for (int i = 0; i < 2048; i++) begin
            a = 11'(i);
            mem[i] = a[7:0] ^ 8'h5A ^ {a[10:8], 5'b00000}; // block number in the top bits
        end
    end

    // bus seen one CLK late, so edges are judged on registered samples
    always @(posedge CLK) begin
        if (RESET) begin
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            cnt          <= 4'd0;
            byte_idx     <= 2'd0;
            listen       <= 1'b0;
            talk         <= 1'b0;
            sda_pull_low <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin // start or repeated start
                listen       <= 1'b1;
                talk         <= 1'b0;
                cnt          <= 4'd0;
                byte_idx     <= 2'd0;
                sda_pull_low <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin // stop
                listen       <= 1'b0;
                talk         <= 1'b0;
                sda_pull_low <= 1'b0;
            end else if (scl && !scl_q) begin
                if (cnt < 4'd8) begin
                    sh <= {sh[6:0], sda}; // ack bit stays out of the byte
                end
                cnt <= cnt + 4'd1;
            end else if (!scl && scl_q) begin
                sda_pull_low <= 1'b0;
                if (listen && cnt == 4'd8) begin
                    sda_pull_low <= (byte_idx != 2'd0) || addr_ok;
                    listen       <= (byte_idx != 2'd0) || addr_ok; // refused, off the bus
                end else if (listen && cnt == 4'd9) begin
                    cnt      <= 4'd0;
                    byte_idx <= byte_idx + 2'd1;
                    case (byte_idx)
                        2'd0: begin
                            blk <= sh[3:1];
                            if (sh[0]) begin // read, first data bit goes out now
                                listen       <= 1'b0;
                                talk         <= 1'b1;
                                sh           <= mem[{sh[3:1], lo}];
                                sda_pull_low <= ~mem[{sh[3:1], lo}][7];
                            end
                        end
                        2'd1:    lo <= sh;
                        default: mem[{blk, lo}] = sh;
                    endcase
                end else if (talk && cnt < 4'd8) begin
                    sda_pull_low <= !sh[7];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire             wr,
    input  wire             rd,
    input  wire ee_addr_t   addr,
    input  wire i2c_byte_t  wr_data,
    output i2c_byte_t       rd_data,
    output logic            busy,
    output logic            ack,
    output logic            nack_err,
    output logic            scl,
    output logic            sda_pull_low,
    input  wire             sda_in
);

    i2c_cmd_t cmd;
    i2c_rsp_t rsp;
    logic     cmd_valid;
    logic     cmd_done;

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .busy      (busy),
        .ack       (ack),
        .nack_err  (nack_err),
        .rd_data   (rd_data),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_done  (cmd_done),
        .rsp       (rsp)
    );

    i2c_bit_engine u_bit_engine (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_done     (cmd_done),
        .rsp          (rsp),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

`default_nettype wire

// ==== rtl/eeprom_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_seq
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire             wr,
    input  wire             rd,
    input  wire ee_addr_t   addr,
    input  wire i2c_byte_t  wr_data,
    output logic            busy,
    output logic            ack,
    output logic            nack_err,
    output i2c_byte_t       rd_data,
    output i2c_cmd_t        cmd,
    output logic            cmd_valid,
    input  wire             cmd_done,
    input  wire i2c_rsp_t   rsp
);

    seq_state_e state;
    ee_req_t    req;
    logic       pend;      // command issued, waiting for cmd_done
    i2c_byte_t  rd_byte;   // held until the stop finishes
    i2c_byte_t  ctrl_byte;

    assign busy      = (state != SEQ_IDLE);
    assign ack       = (state == SEQ_DONE);
    assign cmd_valid = (state != SEQ_IDLE) && (state != SEQ_DONE) && !pend;

    // 1010 + block bits + R/W
    assign ctrl_byte = {`DEV_TYPE, req.addr[10:8], state == SEQ_CTRL_RD};

    always_comb begin
        cmd.op          = I2C_WRITE;
        cmd.data        = '0;
        cmd.master_nack = 1'b0;
        case (state)
            SEQ_START, SEQ_RESTART: cmd.op = I2C_START;
            SEQ_STOP:               cmd.op = I2C_STOP;
            SEQ_CTRL_WR, SEQ_CTRL_RD: cmd.data = ctrl_byte;
            SEQ_ADDR:               cmd.data = req.addr[7:0];
            SEQ_DATA_WR:            cmd.data = req.wdata;
            SEQ_DATA_RD: begin
                cmd.op          = I2C_READ;
                cmd.master_nack = 1'b1; // single byte, so always the last
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= SEQ_IDLE;
            pend     <= 1'b0;
            nack_err <= 1'b0;
        end else begin
            if (cmd_valid) begin
                pend <= 1'b1;
            end
            case (state)
                SEQ_IDLE: begin
                    if (wr || rd) begin // wr wins
                        nack_err <= 1'b0;
                        state    <= SEQ_START;
                    end
                end
                SEQ_DONE: state <= SEQ_IDLE;
                default: begin
                    if (cmd_done) begin
                        pend     <= 1'b0;
                        nack_err <= nack_err | rsp.slave_nack;
                        case (state)
                            SEQ_START:   state <= SEQ_CTRL_WR;
                            SEQ_CTRL_WR: state <= SEQ_ADDR;
                            SEQ_ADDR:    state <= req.is_read ? SEQ_RESTART : SEQ_DATA_WR;
                            SEQ_RESTART: state <= SEQ_CTRL_RD;
                            SEQ_CTRL_RD: state <= SEQ_DATA_RD;
                            SEQ_STOP:    state <= SEQ_DONE;
                            default:     state <= SEQ_STOP; // after either data byte
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == SEQ_IDLE && (wr || rd)) begin
            req.is_read <= !wr;
            req.addr    <= addr;
            req.wdata   <= wr_data;
        end
        if (state == SEQ_DATA_RD && cmd_done) begin
            rd_byte <= rsp.data;
        end
        if (state == SEQ_STOP && cmd_done && req.is_read) begin
            rd_data <= rd_byte; // shows up with ack
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire i2c_cmd_t   cmd,
    input  wire             cmd_valid,
    output logic            cmd_done,
    output i2c_rsp_t        rsp,
    output logic            scl,
    output logic            sda_pull_low,
    input  wire             sda_in
);

    localparam int unsigned QMAX = `SCL_QUARTER - 1;
    localparam int unsigned QW   = (`SCL_QUARTER > 1) ? $clog2(`SCL_QUARTER) : 1;

    logic          active;
    i2c_op_e       op;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;    // quarter within the current bit or condition
    logic [3:0]    bit_cnt;  // 0..7 data, 8 ack
    i2c_byte_t     shreg;
    logic          samp;     // sda_in taken at the end of phase 2
    logic          master_nack_q;
    logic          scl_nxt;
    logic          pull_nxt;
    logic          q_end;

    assign q_end = (qcnt == QW'(QMAX));

    // bus levels for the current quarter, registered below
    always_comb begin
        scl_nxt  = scl;
        pull_nxt = sda_pull_low;
        if (active) begin
            case (op)
                I2C_START: begin
                    scl_nxt  = (phase == 2'd1) || (phase == 2'd2);
                    pull_nxt = phase[1]; // SDA falls while SCL high
                end
                I2C_STOP: begin
                    scl_nxt  = (phase != 2'd0);
                    pull_nxt = (phase < 2'd2); // SDA rises while SCL high
                end
                default: begin
                    scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                    if (bit_cnt == 4'd8) begin
                        pull_nxt = (op == I2C_READ) && !master_nack_q;
                    end else begin
                        pull_nxt = (op == I2C_WRITE) && !shreg[7];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active       <= 1'b0;
            cmd_done     <= 1'b0;
            qcnt         <= '0;
            phase        <= 2'd0;
            bit_cnt      <= 4'd0;
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
        end else begin
            cmd_done     <= 1'b0;
            scl          <= scl_nxt;
            sda_pull_low <= pull_nxt;
            if (!active) begin
                if (cmd_valid) begin
                    active  <= 1'b1;
                    qcnt    <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                end
            end else if (q_end) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3) begin
                    if (op == I2C_START || op == I2C_STOP || bit_cnt == 4'd8) begin
                        active   <= 1'b0;
                        cmd_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end else begin
                qcnt <= qcnt + QW'(1);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!active && cmd_valid) begin
            op            <= cmd.op;
            shreg         <= cmd.data;
            master_nack_q <= cmd.master_nack;
        end else if (active && q_end) begin
            if (phase == 2'd2) begin
                samp <= sda_in;
            end
            if (phase == 2'd3 && bit_cnt < 4'd8 && (op == I2C_WRITE || op == I2C_READ)) begin
                shreg <= {shreg[6:0], samp};
            end
            if (phase == 2'd3 && (op == I2C_START || op == I2C_STOP || bit_cnt == 4'd8)) begin
                rsp.data       <= shreg;
                rsp.slave_nack <= (op == I2C_WRITE) && samp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;
    import i2c_pkg::*;

    typedef logic [10:0] ee_addr_t; // 2K bytes, top 3 bits go in the control byte

    typedef struct packed {
        logic      is_read;
        ee_addr_t  addr;
        i2c_byte_t wdata;
    } ee_req_t;

    typedef enum logic [3:0] {
        SEQ_IDLE    = 4'd0,
        SEQ_START   = 4'd1,
        SEQ_CTRL_WR = 4'd2,
        SEQ_ADDR    = 4'd3,
        SEQ_DATA_WR = 4'd4,
        SEQ_RESTART = 4'd5,
        SEQ_CTRL_RD = 4'd6,
        SEQ_DATA_RD = 4'd7,
        SEQ_STOP    = 4'd8,
        SEQ_DONE    = 4'd9
    } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    typedef logic [7:0] i2c_byte_t;

    // one operation per bit-engine command
    typedef enum logic [1:0] {
        I2C_START = 2'd0, // also used as repeated start
        I2C_STOP  = 2'd1,
        I2C_WRITE = 2'd2,
        I2C_READ  = 2'd3
    } i2c_op_e;

    typedef struct packed {
        i2c_op_e   op;
        i2c_byte_t data;        // byte to send on write
        logic      master_nack; // NACK instead of ACK after a read
    } i2c_cmd_t;

    typedef struct packed {
        i2c_byte_t data;       // byte shifted in on read
        logic      slave_nack; // ack bit was high after a write
    } i2c_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// CLK cycles per quarter of an SCL period
`define SCL_QUARTER 2

// fixed upper nibble of the control byte, 24Cxx family
`define DEV_TYPE 4'b1010

`endif
